// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= ** FAIL **
PASS_MSG  ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG) || ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/cache_array.sv ====
// -------------------------------------------------------------------
// Cache array
// Tag, data and byte-valid RAMs for each way, with hit detection,
// round-robin victim choice, forwarding of the previous write and the
// invalidation sweep.
// -------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cache_array (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  dcache_pkg::addr_t    lookup_addr_i,
	input  dcache_pkg::sel_t     lookup_sel_i,
	output dcache_pkg::lookup_t  lookup_o,
	input  logic                 fill_we_i,
	input  dcache_pkg::addr_t    fill_addr_i,
	input  dcache_pkg::word_t    fill_data_i,
	input  dcache_pkg::sel_t     fill_mask_i,
	input  logic                 sweep_i,
	input  dcache_pkg::set_idx_t sweep_idx_i
);

	dcache_pkg::set_idx_t rd_set;
	dcache_pkg::set_idx_t wr_set;
	dcache_pkg::tag_t     wr_tag;
	dcache_pkg::way_idx_t wr_way;
	dcache_pkg::set_idx_t mask_wr_set;
	dcache_pkg::sel_t     mask_wr_data;

	// Lookup address and selects, aligned with the RAM read data.
	dcache_pkg::set_idx_t rd_set_q;
	dcache_pkg::tag_t     rd_tag_q;
	dcache_pkg::sel_t     rd_sel_q;

	// Copy of the last fill write, used to bypass the RAM read.
	logic                 wr_q;
	dcache_pkg::set_idx_t wr_set_q;
	dcache_pkg::way_idx_t wr_way_q;
	dcache_pkg::tag_t     wr_tag_q;
	dcache_pkg::word_t    wr_data_q;
	dcache_pkg::sel_t     wr_mask_q;

	dcache_pkg::way_idx_t victim_q;

	dcache_pkg::tag_t                way_tag  [dcache_pkg::WAY_COUNT];
	dcache_pkg::word_t               way_data [dcache_pkg::WAY_COUNT];
	dcache_pkg::sel_t                way_mask [dcache_pkg::WAY_COUNT];
	logic [dcache_pkg::WAY_COUNT-1:0] way_match;

	assign rd_set = lookup_addr_i[dcache_pkg::SET_W-1:0];
	assign wr_set = fill_addr_i[dcache_pkg::SET_W-1:0];
	assign wr_tag = fill_addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::SET_W];

	// A line that already holds the tag is updated in place; otherwise the victim is replaced.
	assign wr_way = lookup_o.tag_hit ? lookup_o.hit_way : victim_q;

	assign mask_wr_set  = sweep_i ? sweep_idx_i : wr_set;
	assign mask_wr_data = sweep_i ? '0 : fill_mask_i;

	for (genvar w = 0; w < dcache_pkg::WAY_COUNT; w++) begin : g_way
		logic              way_we;
		logic              fwd;
		dcache_pkg::tag_t  ram_tag;
		dcache_pkg::word_t ram_data;
		dcache_pkg::sel_t  ram_mask;

		assign way_we = fill_we_i && (wr_way == dcache_pkg::way_idx_t'(w));
		assign fwd    = wr_q && (wr_way_q == dcache_pkg::way_idx_t'(w)) && (wr_set_q == rd_set_q);

		dcache_ram #(.DEPTH(dcache_pkg::SET_COUNT), .WIDTH(dcache_pkg::TAG_W)) i_tag_ram (
			.clk_i     (clk_i),
			.rd_addr_i (rd_set),
			.rd_data_o (ram_tag),
			.we_i      (way_we),
			.wr_addr_i (wr_set),
			.wr_data_i (wr_tag)
		);

		dcache_ram #(.DEPTH(dcache_pkg::SET_COUNT), .WIDTH(dcache_pkg::DATA_W)) i_data_ram (
			.clk_i     (clk_i),
			.rd_addr_i (rd_set),
			.rd_data_o (ram_data),
			.we_i      (way_we),
			.wr_addr_i (wr_set),
			.wr_data_i (fill_data_i)
		);

		// The sweep clears this RAM in every way at once.
		dcache_ram #(.DEPTH(dcache_pkg::SET_COUNT), .WIDTH(dcache_pkg::SEL_W)) i_mask_ram (
			.clk_i     (clk_i),
			.rd_addr_i (rd_set),
			.rd_data_o (ram_mask),
			.we_i      (sweep_i || way_we),
			.wr_addr_i (mask_wr_set),
			.wr_data_i (mask_wr_data)
		);

		assign way_tag[w]   = fwd ? wr_tag_q : ram_tag;
		assign way_data[w]  = fwd ? wr_data_q : ram_data;
		assign way_mask[w]  = fwd ? wr_mask_q : ram_mask;
		assign way_match[w] = (way_tag[w] == rd_tag_q) && (|way_mask[w]);
	end

	// Allocation never duplicates a tag within a set, so at most one way matches.
	always_comb begin
		lookup_o = '0;
		for (int w = 0; w < dcache_pkg::WAY_COUNT; w++) begin
			if (way_match[w]) begin
				lookup_o.tag_hit = 1'b1;
				lookup_o.hit_way = dcache_pkg::way_idx_t'(w);
				lookup_o.mask    = way_mask[w];
				lookup_o.data    = way_data[w];
			end
		end
		lookup_o.hit = lookup_o.tag_hit && ((lookup_o.mask & rd_sel_q) == rd_sel_q);
	end

	always_ff @(posedge clk_i) begin
		rd_set_q  <= rd_set;
		rd_tag_q  <= lookup_addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::SET_W];
		rd_sel_q  <= lookup_sel_i;
		wr_set_q  <= wr_set;
		wr_way_q  <= wr_way;
		wr_tag_q  <= wr_tag;
		wr_data_q <= fill_data_i;
		wr_mask_q <= fill_mask_i;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_q     <= 1'b0;
			victim_q <= '0;
		end else begin
			wr_q <= fill_we_i;
			if (fill_we_i && !lookup_o.tag_hit) begin
				victim_q <= victim_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/dcache_ctrl.sv ====
// -------------------------------------------------------------------
// Data cache controller
// Holds the accepted request, runs the sweep, idle and miss states,
// sequences the memory port and merges write data into the array.
// -------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 flush_i,
	input  dcache_pkg::bus_req_t cpu_req_i,
	output dcache_pkg::word_t    cpu_data_o,
	output logic                 cpu_rdy_o,
	output dcache_pkg::bus_req_t mem_req_o,
	input  dcache_pkg::word_t    mem_data_i,
	input  logic                 mem_rdy_i,
	output dcache_pkg::addr_t    lookup_addr_o,
	output dcache_pkg::sel_t     lookup_sel_o,
	input  dcache_pkg::lookup_t  lookup_i,
	output logic                 fill_we_o,
	output dcache_pkg::addr_t    fill_addr_o,
	output dcache_pkg::word_t    fill_data_o,
	output dcache_pkg::sel_t     fill_mask_o,
	output logic                 sweep_o,
	output dcache_pkg::set_idx_t sweep_idx_o,
	output logic                 buf_push_o,
	input  dcache_pkg::bus_req_t buf_head_i,
	input  logic                 buf_full_i,
	input  logic                 buf_empty_i,
	output logic                 buf_pop_o
);

	dcache_pkg::ctrl_state_e state_q;
	dcache_pkg::set_idx_t    sweep_idx_q;
	dcache_pkg::bus_req_t    hold_q;
	logic                    rd_pend_q;

	logic              accept;
	logic              read_miss;
	logic              idle_write;
	logic              mem_fill;
	logic              rd_issue;
	dcache_pkg::word_t byte_mask;
	dcache_pkg::word_t merged_data;
	dcache_pkg::sel_t  merged_mask;

	assign accept    = cpu_rdy_o && (cpu_req_i.op != dcache_pkg::OP_NONE);
	assign read_miss = (hold_q.op == dcache_pkg::OP_READ) && !lookup_i.hit;

	// The processor stalls while the buffer is full or a held read has missed.
	assign cpu_rdy_o  = (state_q == dcache_pkg::ST_IDLE) && !buf_full_i && !read_miss;
	assign cpu_data_o = lookup_i.data;

	assign lookup_addr_o = accept ? cpu_req_i.addr : hold_q.addr;
	assign lookup_sel_o  = accept ? cpu_req_i.sel : hold_q.sel;

	// Writes go to the buffer on the edge that accepts them.
	assign buf_push_o = accept && (cpu_req_i.op == dcache_pkg::OP_WRITE);

	// A miss fetch waits for an empty buffer, so draining never competes with it.
	assign buf_pop_o = mem_rdy_i && !buf_empty_i;
	assign rd_issue  = (state_q == dcache_pkg::ST_MISS_WAIT) && !rd_pend_q &&
		buf_empty_i && mem_rdy_i;

	assign idle_write = (state_q == dcache_pkg::ST_IDLE) && (hold_q.op == dcache_pkg::OP_WRITE);
	assign mem_fill   = (state_q == dcache_pkg::ST_MISS_WAIT) && rd_pend_q && mem_rdy_i;

	// New bytes where selected; the remaining bytes are kept from a resident line.
	always_comb begin
		for (int b = 0; b < dcache_pkg::SEL_W; b++) begin
			byte_mask[b*8 +: 8] = {8{hold_q.sel[b]}};
		end
		merged_data = hold_q.data & byte_mask;
		merged_mask = hold_q.sel;
		if (lookup_i.tag_hit) begin
			merged_data = merged_data | (lookup_i.data & ~byte_mask);
			merged_mask = merged_mask | lookup_i.mask;
		end
	end

	assign fill_we_o   = idle_write || mem_fill;
	assign fill_addr_o = hold_q.addr;
	assign fill_data_o = mem_fill ? mem_data_i : merged_data;
	assign fill_mask_o = mem_fill ? {dcache_pkg::SEL_W{1'b1}} : merged_mask;

	assign sweep_o     = (state_q == dcache_pkg::ST_SWEEP);
	assign sweep_idx_o = sweep_idx_q;

	always_comb begin
		mem_req_o = buf_head_i;
		if (rd_issue) begin
			mem_req_o.op   = dcache_pkg::OP_READ;
			mem_req_o.addr = hold_q.addr;
			mem_req_o.data = hold_q.data;
			mem_req_o.sel  = {dcache_pkg::SEL_W{1'b1}};
		end else if (!buf_pop_o) begin
			mem_req_o.op = dcache_pkg::OP_NONE;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q     <= dcache_pkg::ST_SWEEP;
			sweep_idx_q <= dcache_pkg::set_idx_t'(dcache_pkg::SET_COUNT - 1);
		end else begin
			case (state_q)
				dcache_pkg::ST_SWEEP: begin
					if (sweep_idx_q == '0) begin
						state_q <= dcache_pkg::ST_IDLE;
					end
					sweep_idx_q <= sweep_idx_q - 1'b1;
				end
				dcache_pkg::ST_IDLE: begin
					if (read_miss) begin
						state_q <= dcache_pkg::ST_MISS_WAIT;
					end else if (cpu_rdy_o && flush_i && !accept) begin
						state_q     <= dcache_pkg::ST_SWEEP;
						sweep_idx_q <= dcache_pkg::set_idx_t'(dcache_pkg::SET_COUNT - 1);
					end
				end
				dcache_pkg::ST_MISS_WAIT: begin
					if (mem_fill) begin
						state_q <= dcache_pkg::ST_IDLE;
					end
				end
				default: state_q <= dcache_pkg::ST_IDLE;
			endcase
		end
	end

	// A held write is done after one cycle, a held read once it is answered.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			hold_q.op <= dcache_pkg::OP_NONE;
		end else if (accept) begin
			hold_q <= cpu_req_i;
		end else if (cpu_rdy_o || (hold_q.op == dcache_pkg::OP_WRITE)) begin
			hold_q.op <= dcache_pkg::OP_NONE;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_pend_q <= 1'b0;
		end else if (rd_issue) begin
			rd_pend_q <= 1'b1;
		end else if (mem_rdy_i) begin
			rd_pend_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/dcache_pkg.sv ====
// -------------------------------------------------------------------
// Data cache package
// Shared widths, vector types, operation and state encodings, and the
// request and lookup records used across the cache.
// -------------------------------------------------------------------
`default_nettype none

package dcache_pkg;

	localparam int DATA_W    = 32;
	localparam int SEL_W     = 4;
	localparam int ADDR_W    = 14;
	localparam int SET_COUNT = 8;
	localparam int SET_W     = 3;
	localparam int WAY_COUNT = 2;
	localparam int WAY_W     = 1;
	localparam int TAG_W     = 11;
	localparam int BUF_DEPTH = 2;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [SEL_W-1:0]  sel_t;
	typedef logic [TAG_W-1:0]  tag_t;
	typedef logic [SET_W-1:0]  set_idx_t;
	typedef logic [WAY_W-1:0]  way_idx_t;

	// Bus operation codes, shared by the processor and memory ports.
	typedef enum logic [1:0] {
		OP_NONE  = 2'b00,
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10
	} op_e;

	typedef enum logic [1:0] {
		ST_SWEEP,
		ST_IDLE,
		ST_MISS_WAIT
	} ctrl_state_e;

	// One bus request, 52 bits wide.
	typedef struct packed {
		op_e   op;
		addr_t addr;
		word_t data;
		sel_t  sel;
	} bus_req_t;

	// Lookup result. The mask and data belong to the way that matched the tag.
	typedef struct packed {
		logic     hit;
		logic     tag_hit;
		way_idx_t hit_way;
		sel_t     mask;
		word_t    data;
	} lookup_t;

endpackage

`default_nettype wire

// ==== design/dcache_ram.sv ====
// -------------------------------------------------------------------
// Simple dual-port RAM
// One write port and one read port with registered read data.
// -------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dcache_ram #(
	parameter int DEPTH = dcache_pkg::SET_COUNT,
	parameter int WIDTH = dcache_pkg::DATA_W
) (
	input  logic                 clk_i,
	input  dcache_pkg::set_idx_t rd_addr_i,
	output logic [WIDTH-1:0]     rd_data_o,
	input  logic                 we_i,
	input  dcache_pkg::set_idx_t wr_addr_i,
	input  logic [WIDTH-1:0]     wr_data_i
);

	logic [WIDTH-1:0] mem [DEPTH];

	// A read of the address being written returns the old contents.
	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
// -------------------------------------------------------------------
// Data cache top level
// Connects the controller, the cache array and the write buffer.
// -------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 flush_i,
	input  dcache_pkg::bus_req_t cpu_req_i,
	output dcache_pkg::word_t    cpu_data_o,
	output logic                 cpu_rdy_o,
	output dcache_pkg::bus_req_t mem_req_o,
	input  dcache_pkg::word_t    mem_data_i,
	input  logic                 mem_rdy_i
);

	dcache_pkg::addr_t    lookup_addr;
	dcache_pkg::sel_t     lookup_sel;
	dcache_pkg::lookup_t  lookup;
	logic                 fill_we;
	dcache_pkg::addr_t    fill_addr;
	dcache_pkg::word_t    fill_data;
	dcache_pkg::sel_t     fill_mask;
	logic                 sweep;
	dcache_pkg::set_idx_t sweep_idx;
	logic                 buf_push;
	logic                 buf_pop;
	dcache_pkg::bus_req_t buf_head;
	logic                 buf_full;
	logic                 buf_empty;

	dcache_ctrl i_ctrl (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.flush_i       (flush_i),
		.cpu_req_i     (cpu_req_i),
		.cpu_data_o    (cpu_data_o),
		.cpu_rdy_o     (cpu_rdy_o),
		.mem_req_o     (mem_req_o),
		.mem_data_i    (mem_data_i),
		.mem_rdy_i     (mem_rdy_i),
		.lookup_addr_o (lookup_addr),
		.lookup_sel_o  (lookup_sel),
		.lookup_i      (lookup),
		.fill_we_o     (fill_we),
		.fill_addr_o   (fill_addr),
		.fill_data_o   (fill_data),
		.fill_mask_o   (fill_mask),
		.sweep_o       (sweep),
		.sweep_idx_o   (sweep_idx),
		.buf_push_o    (buf_push),
		.buf_head_i    (buf_head),
		.buf_full_i    (buf_full),
		.buf_empty_i   (buf_empty),
		.buf_pop_o     (buf_pop)
	);

	cache_array i_array (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.lookup_addr_i (lookup_addr),
		.lookup_sel_i  (lookup_sel),
		.lookup_o      (lookup),
		.fill_we_i     (fill_we),
		.fill_addr_i   (fill_addr),
		.fill_data_i   (fill_data),
		.fill_mask_i   (fill_mask),
		.sweep_i       (sweep),
		.sweep_idx_i   (sweep_idx)
	);

	// The pushed entry is the processor request itself.
	write_buffer #(.DEPTH(dcache_pkg::BUF_DEPTH)) i_wbuf (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.push_i      (buf_push),
		.push_data_i (cpu_req_i),
		.pop_i       (buf_pop),
		.head_o      (buf_head),
		.full_o      (buf_full),
		.empty_o     (buf_empty)
	);

endmodule

`default_nettype wire

// ==== design/write_buffer.sv ====
// -------------------------------------------------------------------
// Write buffer
// Circular FIFO of pending memory writes. The head entry is read
// combinationally so it can be driven straight onto the memory port.
// -------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module write_buffer #(
	parameter int DEPTH = dcache_pkg::BUF_DEPTH
) (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 push_i,
	input  dcache_pkg::bus_req_t push_data_i,
	input  logic                 pop_i,
	output dcache_pkg::bus_req_t head_o,
	output logic                 full_o,
	output logic                 empty_o
);

	typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

	dcache_pkg::bus_req_t entries [DEPTH];
	ptr_t                 wr_ptr_q;
	ptr_t                 rd_ptr_q;
	cnt_t                 count_q;

	assign head_o  = entries[rd_ptr_q];
	assign full_o  = (count_q == cnt_t'(DEPTH));
	assign empty_o = (count_q == '0);

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			entries[wr_ptr_q] <= push_data_i;
		end
	end

	// Pointers wrap at DEPTH, so depths that are not a power of two work too.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (pop_i) begin
				rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verif/dcache_input.txt ====
# op addr data sel expect hit
# op is R, W or F; fields in hex; hit is H or M for reads and - otherwise
R 0010 00000000 f 00100010 M
R 0010 00000000 f 00100010 H
R 0021 00000000 f 00210021 M
R 0021 00000000 f 00210021 H
W 0010 aabbccdd 3 00000000 -
R 0010 00000000 f 0010ccdd H
W 0021 11223344 c 00000000 -
R 0021 00000000 f 11220021 H
W 0032 deadbeef 1 00000000 -
R 0032 00000000 e 003200ef M
R 0032 00000000 f 003200ef H
R 0103 00000000 f 01030103 M
R 0203 00000000 f 02030203 M
R 0303 00000000 f 03030303 M
R 0103 00000000 f 01030103 M
R 0303 00000000 f 03030303 H
W 0044 12345678 f 00000000 -
W 0054 a5a5a5a5 6 00000000 -
W 0044 77000000 8 00000000 -
W 0045 9abcdef0 f 00000000 -
W 0065 0f0f0f0f f 00000000 -
R 0044 00000000 f 77345678 H
R 0054 00000000 f 00a5a554 M
R 0045 00000000 f 9abcdef0 H
R 0065 00000000 f 0f0f0f0f H
W 0077 cafef00d f 00000000 -
F 0000 00000000 0 00000000 -
R 0010 00000000 f 0010ccdd M
R 0044 00000000 f 77345678 M
R 0077 00000000 f cafef00d M
R 0010 00000000 f 0010ccdd H

// ==== verif/dcache_properties.sv ====
// ----------------------------------------------------------------------
// Data cache controller properties
// Memory port and write buffer protocol rules, bound to dcache_ctrl.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dcache_properties (
	input logic                 clk_i,
	input logic                 rst_i,
	input dcache_pkg::bus_req_t mem_req_i,
	input logic                 mem_rdy_i,
	input logic                 buf_empty_i,
	input logic                 buf_full_i,
	input logic                 buf_push_i,
	input logic                 cpu_rdy_i,
	input logic                 sweep_i
);

	mem_op_needs_ready: assert property (@(posedge clk_i) disable iff (rst_i)
		(mem_req_i.op != dcache_pkg::OP_NONE) |-> mem_rdy_i)
		else $error("Memory request driven while the memory is not ready.");

	// Memory must be up to date before a miss fetch.
	read_needs_empty_buffer: assert property (@(posedge clk_i) disable iff (rst_i)
		(mem_req_i.op == dcache_pkg::OP_READ) |-> buf_empty_i)
		else $error("Memory read issued while the write buffer holds entries.");

	no_push_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
		buf_push_i |-> !buf_full_i)
		else $error("Push into a full write buffer.");

	// A sweep holds the processor for one cycle per set and then releases it.
	sweep_then_ready: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(sweep_i) |-> ##(dcache_pkg::SET_COUNT - 1) (sweep_i && !cpu_rdy_i)
			##1 (!sweep_i && cpu_rdy_i))
		else $error("Invalidation sweep did not release the processor after one cycle per set.");

endmodule

`default_nettype wire

// ==== verif/dcache_tb.sv ====
// ----------------------------------------------------------------------
// Data cache testbench
// Replays a file of reads, writes and flushes against the cache, models
// a stalling memory and checks read data, hit or miss, sweep length and
// the final memory contents.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

	localparam int          CLK_PERIOD = 40;
	localparam logic [31:0] SEED       = 32'h0bcf8e78;
	localparam int          TIMEOUT    = 200;
	localparam string       STIM_FILE  = "verif/dcache_input.txt";
	localparam logic [31:0] PATTERN_K  = 32'h00010001;
	localparam int          MEM_WORDS  = 2 ** dcache_pkg::ADDR_W;

	logic                 clk_i;
	logic                 rst_i;
	logic                 flush_i;
	dcache_pkg::bus_req_t cpu_req_i;
	dcache_pkg::word_t    cpu_data_o;
	logic                 cpu_rdy_o;
	dcache_pkg::bus_req_t mem_req_o;
	dcache_pkg::word_t    mem_data_i;
	logic                 mem_rdy_i;

	// Memory model and the contents it should hold once all writes land.
	dcache_pkg::word_t mem_model [MEM_WORDS];
	dcache_pkg::word_t shadow    [MEM_WORDS];
	dcache_pkg::addr_t rd_addr_q = '0;
	int                mem_reads = 0;
	int                mem_writes = 0;
	int                writes_sent = 0;
	int                checks = 0;
	int                errors = 0;
	int                timeouts = 0;

	dcache_top i_dcache_top (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.flush_i    (flush_i),
		.cpu_req_i  (cpu_req_i),
		.cpu_data_o (cpu_data_o),
		.cpu_rdy_o  (cpu_rdy_o),
		.mem_req_o  (mem_req_o),
		.mem_data_i (mem_data_i),
		.mem_rdy_i  (mem_rdy_i)
	);

	bind dcache_ctrl dcache_properties i_props (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.mem_req_i   (mem_req_o),
		.mem_rdy_i   (mem_rdy_i),
		.buf_empty_i (buf_empty_i),
		.buf_full_i  (buf_full_i),
		.buf_push_i  (buf_push_o),
		.cpu_rdy_i   (cpu_rdy_o),
		.sweep_i     (sweep_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_w,
		input dcache_pkg::word_t new_w, input dcache_pkg::sel_t sel);
		dcache_pkg::word_t result;
		result = old_w;
		for (int b = 0; b < dcache_pkg::SEL_W; b++) begin
			if (sel[b]) begin
				result[b*8 +: 8] = new_w[b*8 +: 8];
			end
		end
		return result;
	endfunction

	// The memory accepts a request at a rising edge where it is ready.
	always @(posedge clk_i) begin
		if (!rst_i && mem_rdy_i) begin
			if (mem_req_o.op == dcache_pkg::OP_WRITE) begin
				mem_model[mem_req_o.addr] <= merge_bytes(mem_model[mem_req_o.addr],
					mem_req_o.data, mem_req_o.sel);
				mem_writes <= mem_writes + 1;
			end else if (mem_req_o.op == dcache_pkg::OP_READ) begin
				rd_addr_q <= mem_req_o.addr;
				mem_reads <= mem_reads + 1;
			end
		end
	end

	always @(negedge clk_i) begin
		mem_rdy_i  <= (($urandom % 4) != 0);
		mem_data_i <= mem_model[rd_addr_q];
	end

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timeout at %0t ns while waiting for %s.", $time, what);
	endtask

	// Holds the request until the cache is ready, then removes it after the accepting edge.
	task automatic issue_request(input dcache_pkg::op_e op, input dcache_pkg::addr_t addr,
		input dcache_pkg::word_t data, input dcache_pkg::sel_t sel);
		int wait_cnt;
		cpu_req_i.op   = op;
		cpu_req_i.addr = addr;
		cpu_req_i.data = data;
		cpu_req_i.sel  = sel;
		wait_cnt = 0;
		while (!cpu_rdy_o && wait_cnt < TIMEOUT) begin
			@(negedge clk_i);
			wait_cnt++;
		end
		if (!cpu_rdy_o) begin
			report_timeout("request acceptance");
		end
		@(negedge clk_i);
		cpu_req_i.op = dcache_pkg::OP_NONE;
	endtask

	task automatic read_and_check(input dcache_pkg::addr_t addr, input dcache_pkg::sel_t sel,
		input dcache_pkg::word_t exp_w, input logic exp_hit);
		int                reads_at_accept;
		int                wait_cnt;
		logic              hit;
		dcache_pkg::word_t mask;
		issue_request(dcache_pkg::OP_READ, addr, '0, sel);
		reads_at_accept = mem_reads;
		wait_cnt = 0;
		while (!cpu_rdy_o && wait_cnt < TIMEOUT) begin
			@(negedge clk_i);
			wait_cnt++;
		end
		if (!cpu_rdy_o) begin
			report_timeout("read data");
		end
		hit  = (mem_reads == reads_at_accept);
		mask = merge_bytes('0, '1, sel);
		checks += 2;
		assert ((cpu_data_o & mask) == (exp_w & mask)) else begin
			errors++;
			$display("error: %0t ns read of %h returned %h, expected %h",
				$time, addr, cpu_data_o, exp_w);
		end
		assert (hit == exp_hit) else begin
			errors++;
			$display("error: %0t ns read of %h was a %s, expected a %s",
				$time, addr, hit ? "hit" : "miss", exp_hit ? "hit" : "miss");
		end
	endtask

	task automatic check_sweep_length(input logic check_mem);
		int low_cycles;
		low_cycles = 0;
		while (!cpu_rdy_o && low_cycles < TIMEOUT) begin
			if (check_mem) begin
				checks++;
				assert (mem_req_o.op == dcache_pkg::OP_NONE) else begin
					errors++;
					$display("error: %0t ns memory request during the reset sweep", $time);
				end
			end
			low_cycles++;
			@(negedge clk_i);
		end
		if (!cpu_rdy_o) begin
			report_timeout("the end of the sweep");
		end else begin
			checks++;
			assert (low_cycles == dcache_pkg::SET_COUNT) else begin
				errors++;
				$display("error: %0t ns sweep held the processor for %0d cycles, expected %0d",
					$time, low_cycles, dcache_pkg::SET_COUNT);
			end
		end
	endtask

	task automatic flush_and_sweep();
		int wait_cnt;
		flush_i  = 1'b1;
		wait_cnt = 0;
		while (!cpu_rdy_o && wait_cnt < TIMEOUT) begin
			@(negedge clk_i);
			wait_cnt++;
		end
		if (!cpu_rdy_o) begin
			report_timeout("flush acceptance");
		end
		@(negedge clk_i);
		flush_i = 1'b0;
		check_sweep_length(1'b0);
	endtask

	// The buffer is empty once every write sent to the cache has reached memory.
	task automatic wait_for_drain();
		int wait_cnt;
		wait_cnt = 0;
		while (mem_writes != writes_sent && wait_cnt < TIMEOUT) begin
			@(negedge clk_i);
			wait_cnt++;
		end
		if (mem_writes != writes_sent) begin
			report_timeout("the write buffer to drain");
		end
	endtask

	task automatic compare_memory();
		for (int a = 0; a < MEM_WORDS; a++) begin
			checks++;
			assert (mem_model[a] == shadow[a]) else begin
				errors++;
				$display("error: %0t ns memory word %h holds %h, expected %h",
					$time, a, mem_model[a], shadow[a]);
			end
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	initial begin
		int                fd;
		int                n;
		string             line;
		logic [7:0]        opc;
		logic [7:0]        hmc;
		dcache_pkg::addr_t addr;
		dcache_pkg::word_t data;
		dcache_pkg::word_t exp_w;
		dcache_pkg::sel_t  sel;
		void'($urandom(SEED));
		rst_i      = 1'b1;
		flush_i    = 1'b0;
		cpu_req_i  = '0;
		mem_rdy_i  = 1'b0;
		mem_data_i = '0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem_model[a] = dcache_pkg::word_t'(a) * PATTERN_K;
			shadow[a]    = dcache_pkg::word_t'(a) * PATTERN_K;
		end
		repeat (4) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		check_sweep_length(1'b1);
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the stimulus file %s.", STIM_FILE);
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%c %h %h %h %h %c", opc, addr, data, sel, exp_w, hmc);
					if (opc == "R") begin
						read_and_check(addr, sel, exp_w, hmc == "H");
					end else if (opc == "W") begin
						shadow[addr] = merge_bytes(shadow[addr], data, sel);
						writes_sent++;
						issue_request(dcache_pkg::OP_WRITE, addr, data, sel);
					end else if (opc == "F") begin
						flush_and_sweep();
					end else begin
						errors++;
						$display("Unknown operation in the stimulus file: %s", line);
					end
				end
			end
			$fclose(fd);
		end
		wait_for_drain();
		compare_memory();
		finish_run();
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/dcache_pkg.sv
design/dcache_ram.sv
design/write_buffer.sv
design/cache_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verif/dcache_properties.sv
verif/dcache_tb.sv
